// ==== include/dc_est_defs.svh ====
`ifndef DC_EST_DEFS_SVH
`define DC_EST_DEFS_SVH

//////////////////////////////
// data path widths
//////////////////////////////

// one I or Q value
`define DC_SAMPLE_W 16
// complex samples per input word
`define DC_LANES 4
// block accumulator
`define DC_ACC_W 40
// unsigned scale factor
`define DC_SCALE_W 17

//////////////////////////////
// scaling and pipeline
//////////////////////////////

// fraction bits of the scale product
`define DC_FRAC_SHIFT 16
// fixed normalisation
`define DC_NORM_SHIFT 8
// register stages in the multiplier
`define DC_MULT_DELAY 5

`endif

// ==== hdl/dc_data_pkg.sv ====
`include "dc_est_defs.svh"

package dc_data_pkg;

  // four lanes of {Q, I}, I in the low half of each lane
  typedef logic [2*`DC_LANES*`DC_SAMPLE_W-1:0] word_t;

  // one signed I or Q value
  typedef logic signed [`DC_SAMPLE_W-1:0] sample_t;

  // up to eight values added, three bits of growth
  typedef logic signed [`DC_SAMPLE_W+2:0] lane_sum_t;

  // running and final block totals
  typedef logic signed [`DC_ACC_W-1:0] acc_t;

  // packed output word
  typedef logic [2*`DC_SAMPLE_W-1:0] result_t;

endpackage

// ==== hdl/dc_cfg_pkg.sv ====
`include "dc_est_defs.svh"

package dc_cfg_pkg;

  // block geometry, each value is count minus one
  typedef logic [12:0] smp_cnt_t;
  typedef logic [9:0] chp_cnt_t;
  typedef logic [3:0] frm_cnt_t;

  // unsigned, 16 fraction bits
  typedef logic [`DC_SCALE_W-1:0] scale_t;

  // complex keeps I and Q apart, real folds all eight values
  typedef enum logic {
    MODE_COMPLEX = 1'b0,
    MODE_REAL    = 1'b1
  } mode_e;

endpackage

// ==== hdl/dc_sum_if.sv ====
`timescale 1ns/1ps

// reduced sums of one input word, adder to accumulator
interface dc_sum_if;

  logic                   valid;
  // final word of a block, only together with valid
  logic                   last;
  // real mode puts the whole total here
  dc_data_pkg::lane_sum_t sum_i;
  // zero in real mode
  dc_data_pkg::lane_sum_t sum_q;

  modport src (
    output valid,
    output last,
    output sum_i,
    output sum_q
  );

  modport dst (
    input valid,
    input last,
    input sum_i,
    input sum_q
  );

endinterface

// ==== hdl/dc_block_counter.sv ====
`timescale 1ns/1ps

module dc_block_counter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 i_valid,
  input  dc_cfg_pkg::smp_cnt_t i_smp_cnt,
  input  dc_cfg_pkg::chp_cnt_t i_chp_cnt,
  input  dc_cfg_pkg::frm_cnt_t i_frm_cnt,
  output logic                 o_last
);

  dc_cfg_pkg::smp_cnt_t smp_cnt;
  dc_cfg_pkg::chp_cnt_t chp_cnt;
  dc_cfg_pkg::frm_cnt_t frm_cnt;
  logic                 smp_end;
  logic                 chp_end;
  logic                 frm_end;

  assign smp_end = (smp_cnt == i_smp_cnt);
  assign chp_end = (chp_cnt == i_chp_cnt);
  assign frm_end = (frm_cnt == i_frm_cnt);

  // same cycle as the word it marks
  assign o_last = i_valid && smp_end && chp_end && frm_end;

  // sample -> chirp -> frame carry chain
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      smp_cnt <= '0;
      chp_cnt <= '0;
      frm_cnt <= '0;
    end else if (i_valid) begin
      if (!smp_end) begin
        smp_cnt <= smp_cnt + 1'b1;
      end else begin
        smp_cnt <= '0;
        if (!chp_end) begin
          chp_cnt <= chp_cnt + 1'b1;
        end else begin
          chp_cnt <= '0;
          frm_cnt <= frm_end ? '0 : frm_cnt + 1'b1;
        end
      end
    end
  end

  // config stays fixed inside a block, so the count never runs past it
  a_smp_in_range : assert property (@(posedge clk) disable iff (!rst_n)
    smp_cnt <= i_smp_cnt);

endmodule

// ==== hdl/dc_lane_adder.sv ====
`timescale 1ns/1ps
`include "dc_est_defs.svh"

module dc_lane_adder (
  input  logic               clk,
  input  logic               rst_n,
  input  dc_data_pkg::word_t i_data,
  input  logic               i_valid,
  input  logic               i_last,
  input  dc_cfg_pkg::mode_e  i_mode,
  dc_sum_if.src              sum
);

  localparam int HALF   = `DC_LANES / 2;
  localparam int PAIR_W = `DC_SAMPLE_W + 1;

  logic signed [PAIR_W-1:0] pair_i [HALF];
  logic signed [PAIR_W-1:0] pair_q [HALF];
  logic                     s1_valid;
  logic                     s1_last;
  dc_cfg_pkg::mode_e        s1_mode;
  dc_data_pkg::lane_sum_t   tot_i;
  dc_data_pkg::lane_sum_t   tot_q;

  // lane k holds I at 32k and Q right above it
  function automatic dc_data_pkg::sample_t get_val(input dc_data_pkg::word_t w,
                                                   input int k, input bit q);
    return w[(2*k + int'(q))*`DC_SAMPLE_W +: `DC_SAMPLE_W];
  endfunction

  //////////////////////////////
  // stage 1: lane pairs
  //////////////////////////////

  // lanes 0+2 and 1+3; mode travels with the word
  always_ff @(posedge clk) begin
    for (int j = 0; j < HALF; j++) begin
      pair_i[j] <= PAIR_W'(get_val(i_data, j, 1'b0)) + PAIR_W'(get_val(i_data, j + HALF, 1'b0));
      pair_q[j] <= PAIR_W'(get_val(i_data, j, 1'b1)) + PAIR_W'(get_val(i_data, j + HALF, 1'b1));
    end
    s1_mode <= i_mode;
  end

  //////////////////////////////
  // stage 2: word totals
  //////////////////////////////

  always_comb begin
    tot_i = '0;
    tot_q = '0;
    for (int j = 0; j < HALF; j++) begin
      tot_i = tot_i + dc_data_pkg::lane_sum_t'(pair_i[j]);
      tot_q = tot_q + dc_data_pkg::lane_sum_t'(pair_q[j]);
    end
  end

  always_ff @(posedge clk) begin
    if (s1_mode == dc_cfg_pkg::MODE_REAL) begin
      sum.sum_i <= tot_i + tot_q;
      sum.sum_q <= '0;
    end else begin
      sum.sum_i <= tot_i;
      sum.sum_q <= tot_q;
    end
  end

  // strobes follow the data through both stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s1_last   <= 1'b0;
      sum.valid <= 1'b0;
      sum.last  <= 1'b0;
    end else begin
      s1_valid  <= i_valid;
      s1_last   <= i_valid && i_last;
      sum.valid <= s1_valid;
      sum.last  <= s1_last;
    end
  end

endmodule

// ==== hdl/dc_accumulator.sv ====
`timescale 1ns/1ps

module dc_accumulator (
  input  logic              clk,
  input  logic              rst_n,
  dc_sum_if.dst             sum,
  output dc_data_pkg::acc_t o_tot_i,
  output dc_data_pkg::acc_t o_tot_q,
  output logic              o_done
);

  dc_data_pkg::acc_t acc_i;
  dc_data_pkg::acc_t acc_q;
  dc_data_pkg::acc_t next_i;
  dc_data_pkg::acc_t next_q;
  logic              blk_end;

  // sign extension through the signed cast
  assign next_i  = acc_i + dc_data_pkg::acc_t'(sum.sum_i);
  assign next_q  = acc_q + dc_data_pkg::acc_t'(sum.sum_q);
  assign blk_end = sum.valid && sum.last;

  //////////////////////////////
  // running totals
  //////////////////////////////

  // restart at zero on the final word, the next block may follow at once
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_i  <= '0;
      acc_q  <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= blk_end;
      if (blk_end) begin
        acc_i <= '0;
        acc_q <= '0;
      end else if (sum.valid) begin
        acc_i <= next_i;
        acc_q <= next_q;
      end
    end
  end

  // final totals, held until the next done
  always_ff @(posedge clk) begin
    if (blk_end) begin
      o_tot_i <= next_i;
      o_tot_q <= next_q;
    end
  end

  // the adder only marks words it has accepted
  a_last_with_valid : assert property (@(posedge clk) disable iff (!rst_n)
    sum.last |-> sum.valid);

endmodule

// ==== hdl/dc_pipe_mult.sv ====
`timescale 1ns/1ps
`include "dc_est_defs.svh"

module dc_pipe_mult #(
  parameter int DELAY = `DC_MULT_DELAY
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  dc_data_pkg::acc_t                          i_a,
  input  dc_cfg_pkg::scale_t                         i_b,
  output logic signed [`DC_ACC_W+`DC_SCALE_W-1:0]    o_p
);

  localparam int PROD_W = `DC_ACC_W + `DC_SCALE_W;

  logic signed [PROD_W-1:0] prod;
  logic signed [PROD_W-1:0] stage [DELAY];

  // zero-extend the scale so it multiplies as a positive value
  assign prod = i_a * $signed({1'b0, i_b});

  // retiming stages for the multiplier
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < DELAY; k++) begin
        stage[k] <= '0;
      end
    end else begin
      stage[0] <= prod;
      for (int k = 1; k < DELAY; k++) begin
        stage[k] <= stage[k-1];
      end
    end
  end

  assign o_p = stage[DELAY-1];

endmodule

// ==== hdl/dc_scaler.sv ====
`timescale 1ns/1ps
`include "dc_est_defs.svh"

module dc_scaler (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dc_data_pkg::acc_t    i_tot_i,
  input  dc_data_pkg::acc_t    i_tot_q,
  input  logic                 i_done,
  input  dc_cfg_pkg::scale_t   i_scale,
  input  dc_cfg_pkg::mode_e    i_mode,
  output dc_data_pkg::result_t o_result,
  output logic                 o_valid
);

  localparam int PROD_W = `DC_ACC_W + `DC_SCALE_W;
  localparam int SHIFT  = `DC_FRAC_SHIFT + `DC_NORM_SHIFT;
  localparam int RES_W  = $bits(dc_data_pkg::result_t);
  localparam int HALF_W = RES_W / 2;

  logic signed [PROD_W-1:0]  prod_i;
  logic signed [PROD_W-1:0]  prod_q;
  logic signed [PROD_W-1:0]  scl_i;
  logic signed [PROD_W-1:0]  scl_q;
  logic [`DC_MULT_DELAY-1:0] done_dly;
  dc_cfg_pkg::mode_e         mode_dly [`DC_MULT_DELAY];

  dc_pipe_mult #(.DELAY(`DC_MULT_DELAY)) u_mult_i (
    .clk   (clk),
    .rst_n (rst_n),
    .i_a   (i_tot_i),
    .i_b   (i_scale),
    .o_p   (prod_i)
  );

  dc_pipe_mult #(.DELAY(`DC_MULT_DELAY)) u_mult_q (
    .clk   (clk),
    .rst_n (rst_n),
    .i_a   (i_tot_q),
    .i_b   (i_scale),
    .o_p   (prod_q)
  );

  // done and the block's mode ride along with the products
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_dly <= '0;
    end else begin
      done_dly[0] <= i_done;
      for (int k = 1; k < `DC_MULT_DELAY; k++) begin
        done_dly[k] <= done_dly[k-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    mode_dly[0] <= i_mode;
    for (int k = 1; k < `DC_MULT_DELAY; k++) begin
      mode_dly[k] <= mode_dly[k-1];
    end
  end

  // drop fraction and normalise, sign kept in both modes
  assign scl_i = prod_i >>> SHIFT;
  assign scl_q = prod_q >>> SHIFT;

  //////////////////////////////
  // output packing
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_valid  <= 1'b0;
      o_result <= '0;
    end else begin
      o_valid <= done_dly[`DC_MULT_DELAY-1];
      if (done_dly[`DC_MULT_DELAY-1]) begin
        if (mode_dly[`DC_MULT_DELAY-1] == dc_cfg_pkg::MODE_REAL) begin
          o_result <= scl_i[RES_W-1:0];
        end else begin
          // Q high, I low, each as sign plus 15 bits
          o_result <= {scl_q[PROD_W-1], scl_q[HALF_W-2:0],
                       scl_i[PROD_W-1], scl_i[HALF_W-2:0]};
        end
      end
    end
  end

  a_done_to_valid : assert property (@(posedge clk) disable iff (!rst_n)
    i_done |-> ##(`DC_MULT_DELAY + 1) o_valid);

  a_valid_from_done : assert property (@(posedge clk) disable iff (!rst_n)
    o_valid |-> $past(i_done, `DC_MULT_DELAY + 1));

endmodule

// ==== hdl/dc_estimator_top.sv ====
`timescale 1ns/1ps

// block DC estimate; mode and scale hold until 3 cycles past a block's final word
module dc_estimator_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dc_data_pkg::word_t   i_data,
  input  logic                 i_valid,
  input  dc_cfg_pkg::smp_cnt_t i_smp_cnt,
  input  dc_cfg_pkg::chp_cnt_t i_chp_cnt,
  input  dc_cfg_pkg::frm_cnt_t i_frm_cnt,
  input  dc_cfg_pkg::scale_t   i_scale,
  input  dc_cfg_pkg::mode_e    i_mode,
  output dc_data_pkg::result_t o_result,
  output logic                 o_valid
);

  logic              blk_last;
  logic              done;
  dc_data_pkg::acc_t tot_i;
  dc_data_pkg::acc_t tot_q;

  dc_sum_if sum_bus ();

  dc_block_counter u_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_valid   (i_valid),
    .i_smp_cnt (i_smp_cnt),
    .i_chp_cnt (i_chp_cnt),
    .i_frm_cnt (i_frm_cnt),
    .o_last    (blk_last)
  );

  dc_lane_adder u_adder (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_data  (i_data),
    .i_valid (i_valid),
    .i_last  (blk_last),
    .i_mode  (i_mode),
    .sum     (sum_bus.src)
  );

  dc_accumulator u_acc (
    .clk     (clk),
    .rst_n   (rst_n),
    .sum     (sum_bus.dst),
    .o_tot_i (tot_i),
    .o_tot_q (tot_q),
    .o_done  (done)
  );

  dc_scaler u_scaler (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_tot_i  (tot_i),
    .i_tot_q  (tot_q),
    .i_done   (done),
    .i_scale  (i_scale),
    .i_mode   (i_mode),
    .o_result (o_result),
    .o_valid  (o_valid)
  );

endmodule

// ==== verif/tb_dc_estimator.sv ====
`timescale 1ns/1ps
`include "dc_est_defs.svh"

module tb_dc_estimator;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_TESTS  = 8;
  localparam int LATENCY    = 9;
  localparam int SHIFT      = `DC_FRAC_SHIFT + `DC_NORM_SHIFT;
  localparam int SW         = `DC_SAMPLE_W;

  typedef struct {
    string                name;
    dc_cfg_pkg::mode_e    mode;
    dc_cfg_pkg::smp_cnt_t smp;
    dc_cfg_pkg::chp_cnt_t chp;
    dc_cfg_pkg::frm_cnt_t frm;
    dc_cfg_pkg::scale_t   scale;
    bit                   gap;
    int                   nblk;
    bit                   neg;
  } test_t;

  logic                 clk = 1'b0;
  logic                 rst_n;
  dc_data_pkg::word_t   i_data;
  logic                 i_valid;
  dc_cfg_pkg::smp_cnt_t i_smp_cnt;
  dc_cfg_pkg::chp_cnt_t i_chp_cnt;
  dc_cfg_pkg::frm_cnt_t i_frm_cnt;
  dc_cfg_pkg::scale_t   i_scale;
  dc_cfg_pkg::mode_e    i_mode;
  dc_data_pkg::result_t o_result;
  logic                 o_valid;

  test_t                tests [NUM_TESTS];
  logic [31:0]          lfsr = 32'hd25a4391;
  int                   cyc = 0;
  int                   n_seen = 0;
  int                   wd_cycles = 0;
  bit                   wd_armed = 1'b0;
  // expected results in order of block completion
  string                exp_name [$];
  dc_data_pkg::result_t exp_val [$];
  int                   exp_due [$];

  dc_estimator_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_data    (i_data),
    .i_valid   (i_valid),
    .i_smp_cnt (i_smp_cnt),
    .i_chp_cnt (i_chp_cnt),
    .i_frm_cnt (i_frm_cnt),
    .i_scale   (i_scale),
    .i_mode    (i_mode),
    .o_result  (o_result),
    .o_valid   (o_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  //////////////////////////////
  // helpers and checks
  //////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_result(input string name, input dc_data_pkg::result_t exp,
                              input dc_data_pkg::result_t act);
    if (act !== exp) begin
      fail_run($sformatf("error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("error: %s valid expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      fail_run($sformatf("error: %s output cycle expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_reset(input string name);
    check_valid(name, 1'b0, o_valid);
    check_result(name, '0, o_result);
  endtask

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic dc_data_pkg::sample_t next_sample(input bit neg);
    logic [31:0] r;
    if (neg) begin
      r = take_bits(SW - 1);
      return {1'b1, r[SW-2:0]};
    end
    r = take_bits(SW);
    return r[SW-1:0];
  endfunction

  // total times scale, arithmetic shift, then packing
  function automatic dc_data_pkg::result_t model_result(input dc_cfg_pkg::mode_e mode,
                                                        input longint tot_i,
                                                        input longint tot_q,
                                                        input dc_cfg_pkg::scale_t scale);
    longint sc;
    longint si;
    longint sq;
    sc = longint'({47'd0, scale});
    if (mode == dc_cfg_pkg::MODE_REAL) begin
      si = ((tot_i + tot_q) * sc) >>> SHIFT;
      return si[31:0];
    end
    si = (tot_i * sc) >>> SHIFT;
    sq = (tot_q * sc) >>> SHIFT;
    return {sq[63], sq[14:0], si[63], si[14:0]};
  endfunction

  task automatic set_test(input int idx, input string name, input dc_cfg_pkg::mode_e mode,
                          input int smp, input int chp, input int frm,
                          input dc_cfg_pkg::scale_t scale, input bit gap,
                          input int nblk, input bit neg);
    tests[idx].name  = name;
    tests[idx].mode  = mode;
    tests[idx].smp   = dc_cfg_pkg::smp_cnt_t'(smp);
    tests[idx].chp   = dc_cfg_pkg::chp_cnt_t'(chp);
    tests[idx].frm   = dc_cfg_pkg::frm_cnt_t'(frm);
    tests[idx].scale = scale;
    tests[idx].gap   = gap;
    tests[idx].nblk  = nblk;
    tests[idx].neg   = neg;
  endtask

  function automatic int block_words(input test_t t);
    return (int'(t.smp) + 1) * (int'(t.chp) + 1) * (int'(t.frm) + 1);
  endfunction

  //////////////////////////////
  // stimulus and reference
  //////////////////////////////

  task automatic run_test(input test_t t);
    int                   nwords;
    longint               sum_i;
    longint               sum_q;
    dc_data_pkg::word_t   w;
    dc_data_pkg::sample_t vi;
    dc_data_pkg::sample_t vq;
    nwords = block_words(t);
    for (int b = 0; b < t.nblk; b++) begin
      sum_i = 0;
      sum_q = 0;
      for (int n = 0; n < nwords; n++) begin
        for (int k = 0; k < `DC_LANES; k++) begin
          vi = next_sample(t.neg);
          vq = next_sample(t.neg);
          w[2*SW*k +: SW]      = vi;
          w[2*SW*k + SW +: SW] = vq;
          sum_i += longint'(vi);
          sum_q += longint'(vq);
        end
        @(negedge clk);
        i_data    <= w;
        i_valid   <= 1'b1;
        i_mode    <= t.mode;
        i_scale   <= t.scale;
        i_smp_cnt <= t.smp;
        i_chp_cnt <= t.chp;
        i_frm_cnt <= t.frm;
        if (n == nwords - 1) begin
          exp_name.push_back($sformatf("%s_blk%0d", t.name, b));
          exp_val.push_back(model_result(t.mode, sum_i, sum_q, t.scale));
          exp_due.push_back(cyc + LATENCY);
        end
        if (t.gap) begin
          @(negedge clk);
          i_valid <= 1'b0;
        end
      end
    end
    // scale and mode stay put until the last block has left the scaler input
    repeat (4) begin
      @(negedge clk);
      i_valid <= 1'b0;
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (o_valid) begin
        if (exp_val.size() == 0) begin
          fail_run("o_valid pulsed while no block was pending");
        end else begin
          check_result(exp_name[0], exp_val[0], o_result);
          check_latency(exp_name[0], exp_due[0], cyc);
          void'(exp_name.pop_front());
          void'(exp_val.pop_front());
          void'(exp_due.pop_front());
          n_seen++;
        end
      end else if (n_seen == 0) begin
        check_result("reset_hold", '0, o_result);
      end
    end
  end

  initial begin
    wait (wd_armed);
    #(wd_cycles * CLK_PERIOD);
    fail_run("watchdog expired because the expected output never arrived");
  end

  initial begin
    rst_n     = 1'b0;
    i_data    = '0;
    i_valid   = 1'b0;
    i_smp_cnt = '0;
    i_chp_cnt = '0;
    i_frm_cnt = '0;
    i_scale   = '0;
    i_mode    = dc_cfg_pkg::MODE_COMPLEX;

    set_test(0, "cplx_one_word", dc_cfg_pkg::MODE_COMPLEX, 0, 0, 0, 17'h10000, 0, 3, 0);
    set_test(1, "cplx_multi_chirp", dc_cfg_pkg::MODE_COMPLEX, 7, 3, 0, 17'h0c000, 1, 2, 0);
    set_test(2, "real_multi_frame", dc_cfg_pkg::MODE_REAL, 3, 1, 2, 17'h18000, 0, 2, 0);
    set_test(3, "real_one_word", dc_cfg_pkg::MODE_REAL, 0, 0, 0, 17'h08000, 1, 4, 0);
    set_test(4, "scale_zero", dc_cfg_pkg::MODE_COMPLEX, 3, 0, 0, 17'h00000, 0, 2, 0);
    set_test(5, "cplx_max_neg", dc_cfg_pkg::MODE_COMPLEX, 15, 1, 0, 17'h1ffff, 0, 2, 1);
    set_test(6, "real_max_neg", dc_cfg_pkg::MODE_REAL, 15, 0, 1, 17'h1ffff, 1, 2, 1);
    set_test(7, "cplx_back_to_back", dc_cfg_pkg::MODE_COMPLEX, 1, 0, 0, 17'h10000, 0, 6, 0);

    // words plus a margin per block with gaps doubling the word time
    wd_cycles = 10;
    for (int t = 0; t < NUM_TESTS; t++) begin
      wd_cycles += tests[t].nblk * (block_words(tests[t]) * (int'(tests[t].gap) + 1) + 20);
    end
    wd_armed = 1'b1;

    repeat (3) @(posedge clk);
    @(negedge clk);
    check_reset("in_reset");
    rst_n <= 1'b1;
    @(negedge clk);
    check_reset("after_reset");

    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(tests[t]);
    end

    while (exp_val.size() != 0) begin
      @(negedge clk);
    end
    // quiet window to catch stray output strobes
    repeat (12) @(negedge clk);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
hdl/dc_data_pkg.sv
hdl/dc_cfg_pkg.sv
hdl/dc_sum_if.sv
hdl/dc_block_counter.sv
hdl/dc_lane_adder.sv
hdl/dc_accumulator.sv
hdl/dc_pipe_mult.sv
hdl/dc_scaler.sv
hdl/dc_estimator_top.sv
verif/tb_dc_estimator.sv

// ==== Makefile ====
# Verilator build and run for the DC-offset estimator

SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP      ?= tb_dc_estimator
FLIST    ?= flist.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := ALL CHECKS PASSED

SRCS := $(wildcard hdl/*.sv) $(wildcard verif/*.sv) $(wildcard include/*.svh)
BIN  := $(BUILD)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o $(TOP)

# pass or fail comes from the log
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
